// File: rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int SIZE_OP      = 6;
    localparam int SIZE_REG_DIR = 5;
    localparam int SIZE_FUNCT   = 6;
    localparam int SIZE_IMM     = 16;

    // Opcodes of the supported subset
    localparam logic [SIZE_OP-1:0] OP_RTYPE = 6'h00;
    localparam logic [SIZE_OP-1:0] OP_ADDI  = 6'h08;
    localparam logic [SIZE_OP-1:0] OP_SLTI  = 6'h0a;

    // Function codes that only mean something when op is OP_RTYPE
    localparam logic [SIZE_FUNCT-1:0] FN_ADD = 6'h20;
    localparam logic [SIZE_FUNCT-1:0] FN_SUB = 6'h22;
    localparam logic [SIZE_FUNCT-1:0] FN_AND = 6'h24;
    localparam logic [SIZE_FUNCT-1:0] FN_OR  = 6'h25;
    localparam logic [SIZE_FUNCT-1:0] FN_SLT = 6'h2a;

    // Bit positions inside a 32-bit instruction word
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB   = 0;

endpackage

// File: rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    //**************************************************************************
    // Operation handed from decode to the ALU
    //**************************************************************************
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    //**************************************************************************
    // Operand source picked by the forwarding unit
    //**************************************************************************
    typedef enum logic [1:0] {
        // Value read from the register bank
        FWD_BANK = 2'd0,
        // ALU output of the instruction now in execute
        FWD_EX   = 2'd1,
        // Result waiting in the EX/WB register
        FWD_WB   = 2'd2
    } fwd_sel_e;

endpackage

// File: rtl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int FIFO_DEPTH = 4,
    parameter int SIZE       = 32
) (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_push,
    input  logic [SIZE-1:0] i_data,
    input  logic            i_pop,
    output logic            o_valid,
    output logic [SIZE-1:0] o_data,
    output logic            o_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [SIZE-1:0]  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             do_push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop  = i_pop && (count != '0);
    // A full queue can still take a beat when the head leaves in the same cycle
    assign do_push = i_push && ((count != CNT_W'(FIFO_DEPTH)) || do_pop);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    assign o_valid  = (count != '0);
    assign o_data   = mem[rd_ptr];
    // Each slot freed is handed back to the sender at once
    assign o_credit = do_pop;

endmodule

// File: rtl/register_bank.sv
`timescale 1ns/1ps

module register_bank
    import mips_isa_pkg::*;
#(
    parameter int SIZE          = 32,
    parameter int NUM_REGISTERS = 32
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_write_enable,
    input  logic [SIZE_REG_DIR-1:0] i_w_dir,
    input  logic [SIZE-1:0]         i_w_data,
    input  logic [SIZE_REG_DIR-1:0] i_dir_a,
    input  logic [SIZE_REG_DIR-1:0] i_dir_b,
    output logic [SIZE-1:0]         o_reg_a,
    output logic [SIZE-1:0]         o_reg_b
);

    logic [SIZE-1:0] regs [NUM_REGISTERS];
    logic            hit_a;
    logic            hit_b;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGISTERS; i++)
                regs[i] <= '0;
        end else if (i_write_enable && (i_w_dir != '0)) begin
            regs[i_w_dir] <= i_w_data;
        end
    end

    // Write-through so a reader sees the value retiring this very cycle
    assign hit_a = i_write_enable && (i_w_dir == i_dir_a);
    assign hit_b = i_write_enable && (i_w_dir == i_dir_b);

    // Register zero reads as zero whatever is presented on the write port
    assign o_reg_a = (i_dir_a == '0) ? '0 :
                     hit_a           ? i_w_data : regs[i_dir_a];
    assign o_reg_b = (i_dir_b == '0) ? '0 :
                     hit_b           ? i_w_data : regs[i_dir_b];

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic [SIZE_REG_DIR-1:0] i_rs,
    input  logic [SIZE_REG_DIR-1:0] i_rt,
    input  logic [SIZE_REG_DIR-1:0] i_rd_ex,
    input  logic                    i_wr_ex,
    input  logic [SIZE_REG_DIR-1:0] i_rd_wb,
    input  logic                    i_wr_wb,
    output fwd_sel_e                o_forward_a,
    output fwd_sel_e                o_forward_b
);

    //**************************************************************************
    // Source selection with the youngest producer first
    //**************************************************************************
    function automatic fwd_sel_e pick_source(
        input logic [SIZE_REG_DIR-1:0] src,
        input logic [SIZE_REG_DIR-1:0] rd_ex,
        input logic                    wr_ex,
        input logic [SIZE_REG_DIR-1:0] rd_wb,
        input logic                    wr_wb
    );
        fwd_sel_e sel;
        // Register zero always comes from the bank, which holds it at zero
        if (src == '0)
            sel = FWD_BANK;
        else if (wr_ex && (src == rd_ex))
            sel = FWD_EX;
        else if (wr_wb && (src == rd_wb))
            sel = FWD_WB;
        else
            sel = FWD_BANK;
        return sel;
    endfunction

    assign o_forward_a = pick_source(i_rs, i_rd_ex, i_wr_ex, i_rd_wb, i_wr_wb);
    assign o_forward_b = pick_source(i_rt, i_rd_ex, i_wr_ex, i_rd_wb, i_wr_wb);

endmodule

// File: rtl/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
#(
    parameter int SIZE          = 32,
    parameter int NUM_REGISTERS = 32
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_valid,
    input  logic [SIZE-1:0]         i_instruction,
    input  logic [SIZE_REG_DIR-1:0] i_w_dir,
    input  logic [SIZE-1:0]         i_w_data,
    input  logic                    i_write_enable,
    input  logic [SIZE_REG_DIR-1:0] i_ex_rd,
    input  logic                    i_ex_wr,
    input  logic [SIZE-1:0]         i_ex_data,
    input  logic [SIZE_REG_DIR-1:0] i_wb_rd,
    input  logic                    i_wb_wr,
    input  logic [SIZE-1:0]         i_wb_data,
    output logic                    o_pop,
    output logic                    o_valid,
    output alu_op_e                 o_alu_op,
    output logic [SIZE-1:0]         o_reg_a,
    output logic [SIZE-1:0]         o_reg_b,
    output logic [SIZE_REG_DIR-1:0] o_dir_rd,
    output logic                    o_wr
);

    logic [SIZE_OP-1:0]      op;
    logic [SIZE_FUNCT-1:0]   funct;
    logic [SIZE_REG_DIR-1:0] rs;
    logic [SIZE_REG_DIR-1:0] rt;
    logic [SIZE_REG_DIR-1:0] rd;
    logic [SIZE-1:0]         imm_ext;
    logic [SIZE-1:0]         bank_a;
    logic [SIZE-1:0]         bank_b;
    logic [SIZE-1:0]         operand_a;
    logic [SIZE-1:0]         operand_rt;
    logic                    use_imm;
    alu_op_e                 alu_op;
    fwd_sel_e                fwd_a;
    fwd_sel_e                fwd_b;

    function automatic logic [SIZE-1:0] select_operand(
        input fwd_sel_e        sel,
        input logic [SIZE-1:0] bank,
        input logic [SIZE-1:0] ex,
        input logic [SIZE-1:0] wb
    );
        logic [SIZE-1:0] value;
        case (sel)
            FWD_EX:  value = ex;
            FWD_WB:  value = wb;
            default: value = bank;
        endcase
        return value;
    endfunction

    assign op      = i_instruction[OP_LSB +: SIZE_OP];
    assign funct   = i_instruction[FUNCT_LSB +: SIZE_FUNCT];
    assign rs      = i_instruction[RS_LSB +: SIZE_REG_DIR];
    assign rt      = i_instruction[RT_LSB +: SIZE_REG_DIR];
    assign rd      = i_instruction[RD_LSB +: SIZE_REG_DIR];
    assign imm_ext = {{(SIZE - SIZE_IMM){i_instruction[IMM_LSB + SIZE_IMM - 1]}},
                      i_instruction[IMM_LSB +: SIZE_IMM]};
    assign use_imm = (op == OP_ADDI) || (op == OP_SLTI);

    // Anything not recognised falls back to ADD
    always_comb begin
        alu_op = ALU_ADD;
        if (op == OP_SLTI) begin
            alu_op = ALU_SLT;
        end else if (op == OP_RTYPE) begin
            case (funct)
                FN_SUB:  alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    register_bank #(
        .SIZE(SIZE),
        .NUM_REGISTERS(NUM_REGISTERS)
    ) bank_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_write_enable(i_write_enable),
        .i_w_dir(i_w_dir),
        .i_w_data(i_w_data),
        .i_dir_a(rs),
        .i_dir_b(rt),
        .o_reg_a(bank_a),
        .o_reg_b(bank_b)
    );

    forwarding_unit forward_inst (
        .i_rs(rs),
        .i_rt(rt),
        .i_rd_ex(i_ex_rd),
        .i_wr_ex(i_ex_wr),
        .i_rd_wb(i_wb_rd),
        .i_wr_wb(i_wb_wr),
        .o_forward_a(fwd_a),
        .o_forward_b(fwd_b)
    );

    assign operand_a  = select_operand(fwd_a, bank_a, i_ex_data, i_wb_data);
    assign operand_rt = select_operand(fwd_b, bank_b, i_ex_data, i_wb_data);

    assign o_pop = i_valid && !i_stall;

    //**************************************************************************
    // ID/EX register
    //**************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_wr    <= 1'b0;
        end else if (!i_stall) begin
            // An empty queue leaves a bubble in the slot
            o_valid <= i_valid;
            o_wr    <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_alu_op <= alu_op;
            o_reg_a  <= operand_a;
            o_reg_b  <= use_imm ? imm_ext : operand_rt;
            o_dir_rd <= use_imm ? rt : rd;
        end
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
#(
    parameter int SIZE = 32
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_valid,
    input  alu_op_e                 i_alu_op,
    input  logic [SIZE-1:0]         i_a,
    input  logic [SIZE-1:0]         i_b,
    input  logic [SIZE_REG_DIR-1:0] i_rd,
    input  logic                    i_wr,
    output logic [SIZE-1:0]         o_result,
    output logic                    o_valid,
    output logic [SIZE_REG_DIR-1:0] o_rd,
    output logic [SIZE-1:0]         o_data
);

    logic [SIZE-1:0] result;
    logic            less_than;

    assign less_than = $signed(i_a) < $signed(i_b);

    //**************************************************************************
    // ALU
    //**************************************************************************
    always_comb begin
        case (i_alu_op)
            ALU_SUB: result = i_a - i_b;
            ALU_AND: result = i_a & i_b;
            ALU_OR:  result = i_a | i_b;
            ALU_SLT: result = {{(SIZE - 1){1'b0}}, less_than};
            default: result = i_a + i_b;
        endcase
    end

    // Decode looks at this value while the instruction is still in execute
    assign o_result = result;

    //**************************************************************************
    // EX/WB register
    //**************************************************************************
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_valid && i_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_rd   <= i_rd;
            o_data <= result;
        end
    end

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import mips_isa_pkg::*;
#(
    parameter int SIZE        = 32,
    parameter int OUT_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  logic [SIZE_REG_DIR-1:0] i_rd,
    input  logic [SIZE-1:0]         i_data,
    input  logic                    i_credit,
    output logic                    o_stall,
    output logic                    o_wb_valid,
    output logic [SIZE_REG_DIR-1:0] o_wb_dir,
    output logic [SIZE-1:0]         o_wb_data,
    output logic                    o_write_enable
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             handoff;

    assign handoff = i_valid && (credits != '0);

    // A spent credit and a returned one in the same cycle cancel out
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            credits <= CNT_W'(OUT_CREDITS);
        else if (handoff && !i_credit)
            credits <= credits - 1'b1;
        else if (i_credit && !handoff)
            credits <= credits + 1'b1;
    end

    // The bank only takes the result once the sink has accepted it
    assign o_wb_valid     = handoff;
    assign o_write_enable = handoff;
    assign o_wb_dir       = i_rd;
    assign o_wb_data      = i_data;
    assign o_stall        = i_valid && (credits == '0);

endmodule

// File: rtl/mips_core_top.sv
`timescale 1ns/1ps

module mips_core_top
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
#(
    parameter int SIZE          = 32,
    parameter int NUM_REGISTERS = 32,
    parameter int FIFO_DEPTH    = 4,
    parameter int OUT_CREDITS   = 2
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_instr_valid,
    input  logic [SIZE-1:0]         i_instr,
    input  logic                    i_wb_credit,
    output logic                    o_instr_credit,
    output logic                    o_wb_valid,
    output logic [SIZE_REG_DIR-1:0] o_wb_dir,
    output logic [SIZE-1:0]         o_wb_data
);

    logic                    q_valid;
    logic [SIZE-1:0]         q_instr;
    logic                    q_pop;
    logic                    stall;

    logic                    idex_valid;
    alu_op_e                 idex_alu_op;
    logic [SIZE-1:0]         idex_a;
    logic [SIZE-1:0]         idex_b;
    logic [SIZE_REG_DIR-1:0] idex_rd;
    logic                    idex_wr;

    logic [SIZE-1:0]         ex_result;
    logic                    exwb_valid;
    logic [SIZE_REG_DIR-1:0] exwb_rd;
    logic [SIZE-1:0]         exwb_data;
    logic                    wb_write_enable;

    instr_queue #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .SIZE(SIZE)
    ) queue_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_push(i_instr_valid),
        .i_data(i_instr),
        .i_pop(q_pop),
        .o_valid(q_valid),
        .o_data(q_instr),
        .o_credit(o_instr_credit)
    );

    instruction_decode #(
        .SIZE(SIZE),
        .NUM_REGISTERS(NUM_REGISTERS)
    ) decode_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_stall(stall),
        .i_valid(q_valid),
        .i_instruction(q_instr),
        .i_w_dir(exwb_rd),
        .i_w_data(exwb_data),
        .i_write_enable(wb_write_enable),
        .i_ex_rd(idex_rd),
        .i_ex_wr(idex_wr),
        .i_ex_data(ex_result),
        .i_wb_rd(exwb_rd),
        .i_wb_wr(exwb_valid),
        .i_wb_data(exwb_data),
        .o_pop(q_pop),
        .o_valid(idex_valid),
        .o_alu_op(idex_alu_op),
        .o_reg_a(idex_a),
        .o_reg_b(idex_b),
        .o_dir_rd(idex_rd),
        .o_wr(idex_wr)
    );

    execute_stage #(
        .SIZE(SIZE)
    ) execute_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_stall(stall),
        .i_valid(idex_valid),
        .i_alu_op(idex_alu_op),
        .i_a(idex_a),
        .i_b(idex_b),
        .i_rd(idex_rd),
        .i_wr(idex_wr),
        .o_result(ex_result),
        .o_valid(exwb_valid),
        .o_rd(exwb_rd),
        .o_data(exwb_data)
    );

    writeback_stage #(
        .SIZE(SIZE),
        .OUT_CREDITS(OUT_CREDITS)
    ) writeback_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_valid(exwb_valid),
        .i_rd(exwb_rd),
        .i_data(exwb_data),
        .i_credit(i_wb_credit),
        .o_stall(stall),
        .o_wb_valid(o_wb_valid),
        .o_wb_dir(o_wb_dir),
        .o_wb_data(o_wb_data),
        .o_write_enable(wb_write_enable)
    );

endmodule

// File: verif/wb_checker.sv
`timescale 1ns/1ps

module wb_checker
    import mips_isa_pkg::*;
#(
    parameter int SIZE        = 32,
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_instr_valid,
    input  logic [SIZE-1:0]         i_instr,
    input  logic                    i_instr_credit,
    input  logic                    i_wb_valid,
    input  logic [SIZE_REG_DIR-1:0] i_wb_dir,
    input  logic [SIZE-1:0]         i_wb_data,
    input  logic                    i_wb_credit,
    output int                      o_err_alu,
    output int                      o_err_imm,
    output int                      o_err_zero,
    output int                      o_err_out,
    output int                      o_err_in,
    output int                      o_records,
    output int                      o_accepted,
    output int                      o_pops
);

    logic [SIZE-1:0]         model_regs [32];
    logic [SIZE_REG_DIR-1:0] exp_dir [$];
    logic [SIZE-1:0]         exp_data [$];
    string                   exp_tag [$];
    int                      sink_credits;
    int                      in_credits;
    int err_alu  = 0;
    int err_imm  = 0;
    int err_zero = 0;
    int err_out  = 0;
    int err_in   = 0;
    int records  = 0;
    int accepted = 0;
    int pops     = 0;

    assign o_err_alu  = err_alu;
    assign o_err_imm  = err_imm;
    assign o_err_zero = err_zero;
    assign o_err_out  = err_out;
    assign o_err_in   = err_in;
    assign o_records  = records;
    assign o_accepted = accepted;
    assign o_pops     = pops;

    //**************************************************************************
    // Sequential ISA model
    //**************************************************************************
    task automatic model_instr(input logic [SIZE-1:0] instr);
        logic [SIZE_OP-1:0]      op;
        logic [5:0]              funct;
        logic [SIZE_REG_DIR-1:0] rs;
        logic [SIZE_REG_DIR-1:0] rt;
        logic [SIZE_REG_DIR-1:0] dest;
        logic [SIZE-1:0]         a;
        logic [SIZE-1:0]         b;
        logic [SIZE-1:0]         result;
        logic                    imm_form;
        op       = instr[31:26];
        funct    = instr[5:0];
        rs       = instr[25:21];
        rt       = instr[20:16];
        imm_form = (op == OP_ADDI) || (op == OP_SLTI);
        a        = model_regs[rs];
        b        = imm_form ? {{(SIZE - 16){instr[15]}}, instr[15:0]} : model_regs[rt];
        dest     = imm_form ? rt : instr[15:11];
        // Unknown encodings behave as an add
        if (op == OP_SLTI || (op == OP_RTYPE && funct == FN_SLT))
            result = ($signed(a) < $signed(b)) ? 1 : 0;
        else if (op == OP_RTYPE && funct == FN_SUB)
            result = a - b;
        else if (op == OP_RTYPE && funct == FN_AND)
            result = a & b;
        else if (op == OP_RTYPE && funct == FN_OR)
            result = a | b;
        else
            result = a + b;
        if (dest != 0)
            model_regs[dest] = result;
        exp_dir.push_back(dest);
        exp_data.push_back(result);
        if (dest == 0 || rs == 0 || (!imm_form && rt == 0))
            exp_tag.push_back("reg_zero");
        else if (imm_form && instr[15])
            exp_tag.push_back("immediates");
        else
            exp_tag.push_back("alu_results");
    endtask

    task automatic count_error(input string tag);
        if (tag == "immediates")
            err_imm++;
        else if (tag == "reg_zero")
            err_zero++;
        else
            err_alu++;
    endtask

    task automatic check_record();
        logic [SIZE_REG_DIR-1:0] dir;
        logic [SIZE-1:0]         data;
        string                   tag;
        records++;
        if (sink_credits == 0) begin
            err_out++;
            $display("o_wb_valid fired while the sink held no credit at %0t", $time);
        end
        if (exp_data.size() == 0) begin
            err_out++;
            $display("A record retired with no instruction outstanding at %0t", $time);
        end else begin
            dir  = exp_dir.pop_front();
            data = exp_data.pop_front();
            tag  = exp_tag.pop_front();
            if (dir !== i_wb_dir || data !== i_wb_data) begin
                count_error(tag);
                $display("FAIL %s expected r%0d=%08h actual r%0d=%08h",
                         tag, dir, data, i_wb_dir, i_wb_data);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++)
                model_regs[i] = '0;
            sink_credits = OUT_CREDITS;
            in_credits   = FIFO_DEPTH;
            if (i_instr_credit || i_wb_valid) begin
                err_in++;
                $display("A control output was high during reset at %0t", $time);
            end
        end else begin
            if (i_wb_valid)
                check_record();
            sink_credits = sink_credits - i_wb_valid + i_wb_credit;
            if (i_instr_credit)
                pops++;
            if (i_instr_valid) begin
                accepted++;
                model_instr(i_instr);
            end
            in_credits = in_credits + i_instr_credit - i_instr_valid;
            // The queue can never free more slots than it was given
            if (in_credits > FIFO_DEPTH) begin
                err_in++;
                $display("The core returned more input credits than instructions at %0t",
                         $time);
            end
        end
    end

endmodule

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core
    import mips_isa_pkg::*;
;

    localparam int SIZE          = 32;
    localparam int NUM_REGISTERS = 32;
    localparam int FIFO_DEPTH    = 4;
    localparam int OUT_CREDITS   = 2;
    localparam int NUM_INSTR     = 300;
    localparam int CREDIT_LIMIT  = 500;
    localparam int DRAIN_LIMIT   = 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic [SIZE-1:0]         instr;
    logic                    wb_credit;
    logic                    instr_credit;
    logic                    wb_valid;
    logic [SIZE_REG_DIR-1:0] wb_dir;
    logic [SIZE-1:0]         wb_data;

    int err_alu;
    int err_imm;
    int err_zero;
    int err_out;
    int err_in;
    int records;
    int accepted;
    int pops;

    integer seed;
    int     in_credits;
    int     owed;
    int     quiet;
    int     sent;
    int     idle;
    int     wait_cycles;
    int     total;
    bit     timed_out;

    mips_core_top #(
        .SIZE(SIZE),
        .NUM_REGISTERS(NUM_REGISTERS),
        .FIFO_DEPTH(FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) DUT (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_instr_valid(instr_valid),
        .i_instr(instr),
        .i_wb_credit(wb_credit),
        .o_instr_credit(instr_credit),
        .o_wb_valid(wb_valid),
        .o_wb_dir(wb_dir),
        .o_wb_data(wb_data)
    );

    wb_checker #(
        .SIZE(SIZE),
        .FIFO_DEPTH(FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) result_check (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_instr_valid(instr_valid),
        .i_instr(instr),
        .i_instr_credit(instr_credit),
        .i_wb_valid(wb_valid),
        .i_wb_dir(wb_dir),
        .i_wb_data(wb_data),
        .i_wb_credit(wb_credit),
        .o_err_alu(err_alu),
        .o_err_imm(err_imm),
        .o_err_zero(err_zero),
        .o_err_out(err_out),
        .o_err_in(err_in),
        .o_records(records),
        .o_accepted(accepted),
        .o_pops(pops)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Mostly registers 0 to 3, so neighbours keep depending on each other
    task automatic pick_reg(output logic [4:0] r);
        if (({$random(seed)} % 8) != 0)
            r = {$random(seed)} % 4;
        else
            r = {$random(seed)} % 32;
    endtask

    task automatic build_instr(output logic [SIZE-1:0] word);
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  funct;
        kind = {$random(seed)} % 7;
        pick_reg(rs);
        pick_reg(rt);
        pick_reg(rd);
        if (({$random(seed)} % 2) != 0)
            imm = $random(seed);
        else
            imm = 16'(({$random(seed)} % 16) - 8);
        case (kind)
            0:       funct = FN_ADD;
            1:       funct = FN_SUB;
            2:       funct = FN_AND;
            3:       funct = FN_OR;
            default: funct = FN_SLT;
        endcase
        if (kind == 5)
            word = {OP_ADDI, rs, rt, imm};
        else if (kind == 6)
            word = {OP_SLTI, rs, rt, imm};
        else
            word = {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endtask

    //**************************************************************************
    // One falling edge of stimulus with the sink credit return before the sender
    //**************************************************************************
    task automatic step_cycle(input bit allow_send);
        logic [SIZE-1:0] word;
        if (wb_valid)
            owed++;
        wb_credit = 1'b0;
        if (quiet > 0)
            quiet--;
        else if (({$random(seed)} % 32) == 0)
            quiet = 8 + {$random(seed)} % 32;
        else if (owed > 0 && ({$random(seed)} % 2) == 0) begin
            wb_credit = 1'b1;
            owed--;
        end
        if (instr_credit)
            in_credits++;
        instr_valid = 1'b0;
        if (allow_send && in_credits > 0 && ({$random(seed)} % 4) != 0) begin
            build_instr(word);
            instr       = word;
            instr_valid = 1'b1;
            in_credits--;
            sent++;
            idle = 0;
        end else if (allow_send && in_credits == 0) begin
            idle++;
        end
    endtask

    initial begin
        seed        = 32'h8bf4b365;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_credit   = 1'b0;
        in_credits  = FIFO_DEPTH;
        owed        = 0;
        quiet       = 0;
        sent        = 0;
        idle        = 0;
        timed_out   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (sent < NUM_INSTR && !timed_out) begin
            @(negedge clk);
            step_cycle(1'b1);
            if (idle > CREDIT_LIMIT) begin
                $display("Timeout: no input credit came back for %0d cycles", CREDIT_LIMIT);
                timed_out = 1'b1;
            end
        end

        wait_cycles = 0;
        while (!timed_out && records < sent) begin
            @(negedge clk);
            step_cycle(1'b0);
            wait_cycles++;
            if (wait_cycles > DRAIN_LIMIT) begin
                $display("Timeout: only %0d of %0d records retired", records, sent);
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;

        total = err_alu + err_imm + err_zero + err_out + err_in;
        if (!timed_out && (records != sent || accepted != sent)) begin
            total++;
            $display("Record count %0d does not match %0d instructions sent", records, sent);
        end
        if (!timed_out && pops != accepted) begin
            total++;
            $display("Input credits returned %0d differ from %0d accepted", pops, accepted);
        end
        $write("Errors: alu_results %0d, immediates %0d, reg_zero %0d, ",
               err_alu, err_imm, err_zero);
        $display("out_credits %0d, in_credits %0d, total %0d", err_out, err_in, total);
        if (!timed_out && total == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: project.f
rtl/mips_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/instr_queue.sv
rtl/register_bank.sv
rtl/forwarding_unit.sv
rtl/instruction_decode.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mips_core_top.sv
verif/wb_checker.sv
verif/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - rtl/mips_isa_pkg.sv
  - rtl/pipe_ctrl_pkg.sv
  - rtl/instr_queue.sv
  - rtl/register_bank.sv
  - rtl/forwarding_unit.sv
  - rtl/instruction_decode.sv
  - rtl/execute_stage.sv
  - rtl/writeback_stage.sv
  - rtl/mips_core_top.sv
  - target: test
    files:
      - verif/wb_checker.sv
      - verif/tb_mips_core.sv
